// File: rtl/delta_pkg.sv
package delta_pkg;

    // Vector geometry.
    localparam int VECTOR_LEN  = 4;
    localparam int CELL_WIDTH  = 10;
    localparam int DELTA_WIDTH = VECTOR_LEN * CELL_WIDTH;

    // Layer indexing.
    localparam int LAYER_ADDR_WIDTH = 2;
    localparam int LAYER_MAX        = 3;

    localparam int SHIFT_WIDTH = 4;

    // Configuration register map.
    localparam int                        CFG_ADDR_WIDTH   = 1;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_OUTPUT_LAYER = 1'b0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_DELTA_SHIFT  = 1'b1;

    typedef logic signed [CELL_WIDTH-1:0]       cell_t;
    typedef cell_t       [VECTOR_LEN-1:0]       delta_vec_t;
    typedef logic        [LAYER_ADDR_WIDTH-1:0] layer_idx_t;
    typedef logic        [SHIFT_WIDTH-1:0]      shift_t;

    localparam layer_idx_t RESET_OUTPUT_LAYER = layer_idx_t'(LAYER_MAX);
    localparam shift_t     RESET_DELTA_SHIFT  = shift_t'(4);

    // Saturation bounds of one cell.
    localparam cell_t CELL_MAX = {1'b0, {(CELL_WIDTH-1){1'b1}}};
    localparam cell_t CELL_MIN = {1'b1, {(CELL_WIDTH-1){1'b0}}};

endpackage

// File: rtl/bp_config_regs.sv
`timescale 1ns/1ps

module bp_config_regs
    import delta_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [SHIFT_WIDTH-1:0]    cfg_wdata,
    output layer_idx_t                output_layer,
    output shift_t                    delta_shift
);

    layer_idx_t layer_wdata;

    // An index above LAYER_MAX would name a layer that does not exist.
    always_comb begin
        if (cfg_wdata > SHIFT_WIDTH'(LAYER_MAX)) begin
            layer_wdata = layer_idx_t'(LAYER_MAX);
        end else begin
            layer_wdata = cfg_wdata[LAYER_ADDR_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            output_layer <= RESET_OUTPUT_LAYER;
        end else if (cfg_we && cfg_addr == CFG_OUTPUT_LAYER) begin
            output_layer <= layer_wdata; // Clipped index.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            delta_shift <= RESET_DELTA_SHIFT;
        end else if (cfg_we && cfg_addr == CFG_DELTA_SHIFT) begin
            delta_shift <= cfg_wdata;
        end
    end

endmodule

// File: rtl/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer
    import delta_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  layer_idx_t output_layer,
    input  logic       layer_ready,
    output layer_idx_t layer,
    output logic       layer_valid,
    output logic       busy,
    output logic       done
);

    logic layer_xfer;

    assign layer_xfer  = layer_valid && layer_ready;
    // An index is on offer for the whole pass.
    assign layer_valid = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0; // Single-cycle pulse.
            if (!busy && start) begin
                busy <= 1'b1;
            end else if (layer_xfer && layer == '0) begin
                busy <= 1'b0; // Layer 0 was the last one.
                done <= 1'b1;
            end
        end
    end

    // Index register counts down one step per transfer.
    always_ff @(posedge clk) begin
        if (rst) begin
            layer <= '0;
        end else if (!busy && start) begin
            layer <= output_layer;
        end else if (layer_xfer && layer != '0) begin
            layer <= layer - 1'b1;
        end
    end

endmodule

// File: rtl/error_fetcher.sv
`timescale 1ns/1ps

module error_fetcher
    import delta_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  delta_vec_t target,
    input  delta_vec_t activation,
    input  logic       fetch_valid,
    output logic       fetch_ready,
    output delta_vec_t fetch_delta,
    output logic       fetch_delta_valid,
    input  logic       fetch_delta_ready
);

    delta_vec_t diff;

    // Difference at one extra bit, then clamp to the cell range.
    function automatic cell_t sat_diff(input cell_t a, input cell_t b);
        logic signed [CELL_WIDTH:0] d;
        d = a - b;
        if (d[CELL_WIDTH] != d[CELL_WIDTH-1]) begin
            return d[CELL_WIDTH] ? CELL_MIN : CELL_MAX;
        end
        return d[CELL_WIDTH-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < VECTOR_LEN; i++) begin
            diff[i] = sat_diff(target[i], activation[i]);
        end
    end

    // Output stage empty or draining this cycle.
    assign fetch_ready = !fetch_delta_valid || fetch_delta_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_delta_valid <= 1'b0;
        end else if (fetch_ready) begin
            fetch_delta_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            fetch_delta <= diff;
        end
    end

endmodule

// File: rtl/delta_propagator.sv
`timescale 1ns/1ps

module delta_propagator
    import delta_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  delta_vec_t error_in,
    input  delta_vec_t derivative,
    input  logic       prop_valid,
    output logic       prop_ready,
    input  shift_t     delta_shift,
    output delta_vec_t prop_delta,
    output logic       prop_delta_valid,
    input  logic       prop_delta_ready
);

    typedef logic signed [2*CELL_WIDTH-1:0] prod_t;

    prod_t prod_q [VECTOR_LEN]; // Stage one products.
    logic  s1_valid;
    logic  s1_advance;
    logic  s2_advance;

    // Arithmetic shift, then clamp when the upper bits are not all sign.
    function automatic cell_t shift_sat(input prod_t p, input shift_t s);
        prod_t x;
        x = p >>> s;
        if (&x[2*CELL_WIDTH-1:CELL_WIDTH-1] || !(|x[2*CELL_WIDTH-1:CELL_WIDTH-1])) begin
            return x[CELL_WIDTH-1:0];
        end
        return x[2*CELL_WIDTH-1] ? CELL_MIN : CELL_MAX;
    endfunction

    assign s2_advance = !prop_delta_valid || prop_delta_ready;
    assign s1_advance = !s1_valid || s2_advance;
    assign prop_ready = s1_advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid         <= 1'b0;
            prop_delta_valid <= 1'b0;
        end else begin
            if (s1_advance) begin
                s1_valid <= prop_valid;
            end
            if (s2_advance) begin
                prop_delta_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < VECTOR_LEN; i++) begin
            if (prop_valid && s1_advance) begin
                prod_q[i] <= error_in[i] * derivative[i]; // Full-width signed product.
            end
            if (s1_valid && s2_advance) begin
                prop_delta[i] <= shift_sat(prod_q[i], delta_shift);
            end
        end
    end

endmodule

// File: rtl/delta_picker.sv
`timescale 1ns/1ps

module delta_picker
    import delta_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  layer_idx_t output_layer,
    input  layer_idx_t layer,
    input  logic       layer_valid,
    output logic       layer_ready,
    input  delta_vec_t fetch_delta,
    input  logic       fetch_delta_valid,
    output logic       fetch_delta_ready,
    input  delta_vec_t prop_delta,
    input  logic       prop_delta_valid,
    output logic       prop_delta_ready,
    output delta_vec_t delta,
    output layer_idx_t delta_layer,
    output logic       delta_valid,
    input  logic       delta_ready
);

    typedef enum logic {IDLE, DONE} state_t;

    state_t     state;
    layer_idx_t layer_buf;
    logic       layer_set;
    delta_vec_t fetch_buf;
    logic       fetch_set;
    delta_vec_t prop_buf;
    logic       prop_set;
    logic       sel_fetch;
    logic       sel_set;
    logic       release_now;

    assign sel_fetch   = layer_buf == output_layer; // Output layer takes the fetcher.
    assign sel_set     = sel_fetch ? fetch_set : prop_set;
    assign release_now = delta_valid && delta_ready;

    assign layer_ready       = !layer_set;
    assign fetch_delta_ready = !fetch_set;
    assign prop_delta_ready  = !prop_set;

    assign delta_valid = state == DONE;
    assign delta       = sel_fetch ? fetch_buf : prop_buf;
    assign delta_layer = layer_buf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            layer_set <= 1'b0;
            fetch_set <= 1'b0;
            prop_set  <= 1'b0;
        end else begin
            if (state == IDLE && layer_set && sel_set) begin
                state <= DONE;
            end else if (release_now) begin
                state <= IDLE;
            end
            // Empty buffers fill and the selected pair clears on release.
            if (layer_valid && !layer_set) begin
                layer_set <= 1'b1;
            end else if (release_now) begin
                layer_set <= 1'b0;
            end
            if (fetch_delta_valid && !fetch_set) begin
                fetch_set <= 1'b1;
            end else if (release_now && sel_fetch) begin
                fetch_set <= 1'b0;
            end
            if (prop_delta_valid && !prop_set) begin
                prop_set <= 1'b1;
            end else if (release_now && !sel_fetch) begin
                prop_set <= 1'b0; // Fetcher buffer waits for its own layer.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (layer_valid && !layer_set) begin
            layer_buf <= layer;
        end
        if (fetch_delta_valid && !fetch_set) begin
            fetch_buf <= fetch_delta;
        end
        if (prop_delta_valid && !prop_set) begin
            prop_buf <= prop_delta;
        end
    end

endmodule

// File: rtl/backprop_delta_top.sv
`timescale 1ns/1ps

module backprop_delta_top
    import delta_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cfg_we,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [SHIFT_WIDTH-1:0]    cfg_wdata,
    input  logic                      start,
    output logic                      busy,
    output logic                      done,
    input  delta_vec_t                target,
    input  delta_vec_t                activation,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  delta_vec_t                error_in,
    input  delta_vec_t                derivative,
    input  logic                      prop_valid,
    output logic                      prop_ready,
    output delta_vec_t                delta,
    output layer_idx_t                delta_layer,
    output logic                      delta_valid,
    input  logic                      delta_ready
);

    layer_idx_t output_layer;
    shift_t     delta_shift;
    layer_idx_t layer;
    logic       layer_valid;
    logic       layer_ready;
    delta_vec_t fetch_delta;
    logic       fetch_delta_valid;
    logic       fetch_delta_ready;
    delta_vec_t prop_delta;
    logic       prop_delta_valid;
    logic       prop_delta_ready;

    bp_config_regs u_cfg (
        .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata,
        .output_layer, .delta_shift
    );

    layer_sequencer u_seq (
        .clk, .rst, .start, .output_layer, .layer_ready,
        .layer, .layer_valid, .busy, .done
    );

    error_fetcher u_fetch (
        .clk, .rst, .target, .activation, .fetch_valid, .fetch_ready,
        .fetch_delta, .fetch_delta_valid, .fetch_delta_ready
    );

    delta_propagator u_prop (
        .clk, .rst, .error_in, .derivative, .prop_valid, .prop_ready,
        .delta_shift, .prop_delta, .prop_delta_valid, .prop_delta_ready
    );

    delta_picker u_pick (
        .clk, .rst, .output_layer, .layer, .layer_valid, .layer_ready,
        .fetch_delta, .fetch_delta_valid, .fetch_delta_ready,
        .prop_delta, .prop_delta_valid, .prop_delta_ready,
        .delta, .delta_layer, .delta_valid, .delta_ready
    );

endmodule

// File: sim/backprop_delta_props.sv
`timescale 1ns/1ps

module backprop_delta_props
    import delta_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input delta_vec_t delta,
    input layer_idx_t delta_layer,
    input logic       delta_valid,
    input logic       delta_ready,
    input logic       busy,
    input logic       done
);

    // A stalled result keeps its data and tag.
    stall_holds_result: assert property (
        @(posedge clk) disable iff (rst)
        delta_valid && !delta_ready |=> delta_valid && $stable(delta) && $stable(delta_layer)
    ) else $error("Result stream changed while stalled");

    done_ends_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> $past(busy)
    ) else $error("done pulsed without a pass running");

    no_result_after_reset: assert property (
        @(posedge clk) rst |=> !delta_valid
    ) else $error("delta_valid high in the cycle after reset");

endmodule

// File: sim/tb_backprop_delta.sv
`timescale 1ns/1ps

module tb_backprop_delta
    import delta_pkg::*;
();

    localparam logic [31:0] SEED = 32'h45af5e98;
    localparam int NUM_PASSES     = 16;
    localparam int TIMEOUT_CYCLES = NUM_PASSES * (LAYER_MAX + 1) * 64 + 200;
    localparam int CELL_HI        = (1 << (CELL_WIDTH - 1)) - 1;
    localparam int CELL_LO        = -(1 << (CELL_WIDTH - 1));

    logic                      clk;
    logic                      rst;
    logic                      cfg_we;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [SHIFT_WIDTH-1:0]    cfg_wdata;
    logic                      start;
    logic                      busy;
    logic                      done;
    delta_vec_t                target;
    delta_vec_t                activation;
    logic                      fetch_valid;
    logic                      fetch_ready;
    delta_vec_t                error_in;
    delta_vec_t                derivative;
    logic                      prop_valid;
    logic                      prop_ready;
    delta_vec_t                delta;
    layer_idx_t                delta_layer;
    logic                      delta_valid;
    logic                      delta_ready;

    delta_vec_t fetch_q[$]; // Expected output-layer deltas.
    delta_vec_t prop_q[$];  // Expected hidden-layer deltas.
    int         cur_out_layer;
    int         cur_shift;
    int         error_count = 0;
    int         errors_before = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         done_count = 0;
    int         cycle_count = 0;
    int         layer_writes[4] = '{1, 0, 2, 9}; // Last one is above LAYER_MAX.

    backprop_delta_top u_dut (.*);

    bind backprop_delta_top backprop_delta_props u_props (
        .clk(clk), .rst(rst), .delta(delta), .delta_layer(delta_layer),
        .delta_valid(delta_valid), .delta_ready(delta_ready), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (!rst && done) begin
            done_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic cell_t clamp_cell(input int value);
        if (value > CELL_HI) begin
            return cell_t'(CELL_HI);
        end
        if (value < CELL_LO) begin
            return cell_t'(CELL_LO);
        end
        return cell_t'(value);
    endfunction

    // Extreme cells sit within 8 of either end of the range.
    function automatic delta_vec_t random_vec(input bit extreme);
        delta_vec_t v;
        int         offset;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            offset = int'($urandom % 8);
            if (!extreme) begin
                v[i] = cell_t'($urandom);
            end else if ($urandom % 2 == 1) begin
                v[i] = cell_t'(CELL_HI - offset);
            end else begin
                v[i] = cell_t'(CELL_LO + offset);
            end
        end
        return v;
    endfunction

    task automatic model_delta(input bit from_fetch, input delta_vec_t a, input delta_vec_t b);
        delta_vec_t exp_vec;
        int         product;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            if (from_fetch) begin
                exp_vec[i] = clamp_cell(int'(a[i]) - int'(b[i])); // Target minus activation.
            end else begin
                product    = int'(a[i]) * int'(b[i]);
                exp_vec[i] = clamp_cell(product >>> cur_shift);
            end
        end
        if (from_fetch) begin
            fetch_q.push_back(exp_vec);
        end else begin
            prop_q.push_back(exp_vec);
        end
    endtask

    task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input int value);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = SHIFT_WIDTH'(value);
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr == CFG_OUTPUT_LAYER) begin
            cur_out_layer = (value > LAYER_MAX) ? LAYER_MAX : value;
        end else begin
            cur_shift = value;
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (busy) begin
            start = 1'b1; // Second start lands while busy.
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    task automatic send_fetch(input bit extreme);
        delta_vec_t t;
        delta_vec_t a;
        t = random_vec(extreme);
        a = random_vec(extreme);
        model_delta(1'b1, t, a);
        target      = t;
        activation  = a;
        fetch_valid = 1'b1;
        while (!fetch_ready) @(negedge clk);
        @(negedge clk); // Accepted at the edge in between.
        fetch_valid = 1'b0;
    endtask

    task automatic send_props(input int count, input bit extreme);
        delta_vec_t e;
        delta_vec_t d;
        for (int n = 0; n < count; n++) begin
            e = random_vec(extreme);
            d = random_vec(extreme);
            model_delta(1'b0, e, d);
            error_in   = e;
            derivative = d;
            prop_valid = 1'b1;
            while (!prop_ready) @(negedge clk);
            @(negedge clk);
        end
        prop_valid = 1'b0;
    endtask

    task automatic collect_results(input int count);
        int         got;
        int         exp_layer;
        bit         has_exp;
        delta_vec_t exp_vec;
        got       = 0;
        exp_layer = cur_out_layer;
        while (got < count) begin
            @(negedge clk);
            delta_ready = ($urandom % 10) >= 3; // Stalls about 30% of cycles.
            if (delta_valid && delta_ready) begin
                assert (delta_layer == layer_idx_t'(exp_layer)) else begin
                    $display("FAIL at %0t ns: delta_layer %0d, expected %0d",
                             $time, delta_layer, exp_layer);
                    error_count++;
                end
                has_exp = (exp_layer == cur_out_layer) ? fetch_q.size() > 0 : prop_q.size() > 0;
                assert (has_exp) else begin
                    $display("A result for layer %0d came out with no matching input sent",
                             exp_layer);
                    error_count++;
                end
                if (has_exp) begin
                    if (exp_layer == cur_out_layer) begin
                        exp_vec = fetch_q.pop_front();
                    end else begin
                        exp_vec = prop_q.pop_front();
                    end
                    assert (delta == exp_vec) else begin
                        $display("FAIL at %0t ns: layer %0d delta %h, expected %h",
                                 $time, exp_layer, delta, exp_vec);
                        error_count++;
                    end
                end
                got++;
                exp_layer--;
            end
        end
    endtask

    task automatic run_pass(input bit extreme);
        int done_before;
        done_before = done_count;
        @(negedge clk);
        fork
            pulse_start();
            send_fetch(extreme);
            send_props(cur_out_layer, extreme);
            collect_results(cur_out_layer + 1);
        join
        while (done_count == done_before) @(negedge clk);
        repeat (5) @(negedge clk);
        assert (done_count == done_before + 1) else begin
            $display("done pulsed %0d times in one pass", done_count - done_before);
            error_count++;
        end
        assert (!busy && !delta_valid) else begin
            $display("Another pass was running after the expected one ended");
            error_count++;
        end
        assert (fetch_q.size() == 0 && prop_q.size() == 0) else begin
            $display("Some input vectors never came back as results");
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        cfg_we        = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        start         = 1'b0;
        target        = '0;
        activation    = '0;
        fetch_valid   = 1'b0;
        error_in      = '0;
        derivative    = '0;
        prop_valid    = 1'b0;
        delta_ready   = 1'b0;
        cur_out_layer = int'(RESET_OUTPUT_LAYER);
        cur_shift     = int'(RESET_DELTA_SHIFT);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        assert (!delta_valid && !busy && !done && fetch_ready && prop_ready) else begin
            $display("FAIL at %0t ns: outputs not idle after reset", $time);
            error_count++;
        end
        run_pass(1'b0);
        finish_test("reset_and_default_pass");

        repeat (3) run_pass(1'b1);
        finish_test("fetch_saturation");

        repeat (4) begin
            write_cfg(CFG_DELTA_SHIFT, int'($urandom % 16));
            run_pass(1'b0);
        end
        finish_test("shift_sweep");

        repeat (4) run_pass($urandom % 2 == 1);
        finish_test("back_pressure");

        for (int k = 0; k < 4; k++) begin
            write_cfg(CFG_OUTPUT_LAYER, layer_writes[k]);
            run_pass(1'b0);
        end
        finish_test("output_layer_rewrite");

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/delta_pkg.sv
rtl/bp_config_regs.sv
rtl/layer_sequencer.sv
rtl/error_fetcher.sv
rtl/delta_propagator.sv
rtl/delta_picker.sv
rtl/backprop_delta_top.sv
sim/backprop_delta_props.sv
sim/tb_backprop_delta.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_backprop_delta
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The recipe fails unless the pass line shows up in the output.
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
